// ==== verilog/eccPkg.sv ====
/*
 * ECC decoder package
 * Word widths, the SEC-DED code table and the operating mode encoding
 * shared by the pipeline stages and the testbench.
 */
package eccPkg;

   localparam int dataWidth  = 16;   // Data word bits
   localparam int checkWidth = 6;    // Check and syndrome bits
   localparam int byteWidth  = 8;    // Bits covered by each byte parity

   // Check-bit pattern of each data bit.
   // All entries carry three ones, so any double error leaves an even,
   // nonzero syndrome that can never alias a single-bit error.
   // Each check bit covers exactly eight data bits.
   localparam logic [checkWidth-1:0] dataColumns [0:dataWidth-1] = '{
      6'b001101,   // d0
      6'b001110,   // d1
      6'b010011,   // d2
      6'b010101,   // d3
      6'b010110,   // d4
      6'b011001,   // d5
      6'b011010,   // d6
      6'b011100,   // d7
      6'b100011,   // d8
      6'b100101,   // d9
      6'b100110,   // d10
      6'b101001,   // d11
      6'b101010,   // d12
      6'b101100,   // d13
      6'b110001,   // d14
      6'b110010    // d15
   };

   // Operating mode
   // The spare code 2'd3 is decoded like modeDetect
   typedef enum logic [1:0] {
      modeEncode  = 2'd0,   // Syndrome output carries generated check bits
      modeDetect  = 2'd1,   // Report errors, leave data alone
      modeCorrect = 2'd2    // Report errors, fix single data-bit errors
   } opMode_t;

endpackage

// ==== verilog/syndromeStage.sv ====
/*
 * Syndrome stage
 * First pipeline stage. Builds the six parity trees from the code table,
 * folds in the incoming check bits and registers syndrome, mode and strobe.
 */
`timescale 1ns/1ps

module syndromeStage
   import eccPkg::*;
(
   input  logic                  clk_i,
   input  logic                  rstN_i,
   input  logic                  inValid_i,
   input  logic [dataWidth-1:0]  dataWord_i,
   input  logic [checkWidth-1:0] checkBits_i,
   input  opMode_t               mode_i,
   output logic [checkWidth-1:0] syndrome_o,
   output opMode_t               mode_o,
   output logic                  valid_o
);

   logic [checkWidth-1:0] maskedCheck;
   logic [checkWidth-1:0] syndromeD;

   // Encode mode ignores the received check bits
   assign maskedCheck = (mode_i == modeEncode) ? '0 : checkBits_i;

   always_comb begin
      syndromeD = maskedCheck;
      for (int j = 0; j < checkWidth; j++) begin
         for (int i = 0; i < dataWidth; i++) begin
            if (dataColumns[i][j]) begin
               syndromeD[j] = syndromeD[j] ^ dataWord_i[i];   // Parity tree j
            end
         end
      end
   end

   always_ff @(posedge clk_i or negedge rstN_i) begin
      if (!rstN_i) begin
         valid_o <= 1'b0;
         mode_o  <= modeEncode;
      end else begin
         valid_o <= inValid_i;       // Strobe moves every cycle
         if (inValid_i) begin
            mode_o <= mode_i;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (inValid_i) begin
         syndrome_o <= syndromeD;
      end
   end

endmodule

// ==== verilog/byteParityStage.sv ====
/*
 * Byte parity stage
 * First pipeline stage beside the syndrome stage. Registers the raw data
 * word with the even parity of its low and high byte.
 */
`timescale 1ns/1ps

module byteParityStage
   import eccPkg::*;
(
   input  logic                 clk_i,
   input  logic                 rstN_i,
   input  logic                 inValid_i,
   input  logic [dataWidth-1:0] dataWord_i,
   output logic [dataWidth-1:0] data_o,
   output logic                 parityLo_o,
   output logic                 parityHi_o
);

   logic parityLoD;
   logic parityHiD;

   assign parityLoD = ^dataWord_i[byteWidth-1:0];           // Low byte
   assign parityHiD = ^dataWord_i[dataWidth-1:byteWidth];   // High byte

   always_ff @(posedge clk_i or negedge rstN_i) begin
      if (!rstN_i) begin
         data_o     <= '0;
         parityLo_o <= 1'b0;
         parityHi_o <= 1'b0;
      end else if (inValid_i) begin
         data_o     <= dataWord_i;
         parityLo_o <= parityLoD;
         parityHi_o <= parityHiD;
      end
   end

endmodule

// ==== verilog/correctionStage.sv ====
/*
 * Correction stage
 * Second pipeline stage. Decodes the syndrome to the data bit in error,
 * corrects it in correct mode, patches the byte parity of the corrected
 * byte and flags errors that cannot be corrected.
 */
`timescale 1ns/1ps

module correctionStage
   import eccPkg::*;
(
   input  logic                  clk_i,
   input  logic                  rstN_i,
   input  logic                  valid_i,
   input  logic [checkWidth-1:0] syndrome_i,
   input  opMode_t               mode_i,
   input  logic [dataWidth-1:0]  data_i,
   input  logic                  parityLo_i,
   input  logic                  parityHi_i,
   output logic                  valid_o,
   output logic [dataWidth-1:0]  dataWord_o,
   output logic [checkWidth-1:0] syndrome_o,
   output logic                  parityLo_o,
   output logic                  parityHi_o,
   output logic                  uncorrError_o
);

   logic [dataWidth-1:0] errorVec;       // One-hot bit in error
   logic                 corrFlagLo;
   logic                 corrFlagHi;
   logic                 checkBitError;
   logic                 syndromeNonZero;
   logic                 doCorrect;
   logic [dataWidth-1:0] dataD;
   logic                 parityLoD;
   logic                 parityHiD;
   logic                 uncorrD;

   // Match the syndrome against every column of the code table
   always_comb begin
      for (int i = 0; i < dataWidth; i++) begin
         errorVec[i] = (syndrome_i == dataColumns[i]);
      end
   end

   assign corrFlagLo      = |errorVec[byteWidth-1:0];
   assign corrFlagHi      = |errorVec[dataWidth-1:byteWidth];
   assign checkBitError   = $onehot(syndrome_i);   // Weight one, check bit hit
   assign syndromeNonZero = |syndrome_i;
   assign doCorrect       = (mode_i == modeCorrect);

   assign dataD     = doCorrect ? (data_i ^ errorVec) : data_i;
   assign parityLoD = parityLo_i ^ (doCorrect & corrFlagLo);   // Flipped bit flips parity
   assign parityHiD = parityHi_i ^ (doCorrect & corrFlagHi);

   always_comb begin
      case (mode_i)
         modeEncode: begin
            uncorrD = 1'b0;
         end
         modeCorrect: begin
            uncorrD = syndromeNonZero & ~checkBitError & ~(corrFlagLo | corrFlagHi);
         end
         default: begin
            // Detect mode fixes nothing, so a data-bit hit counts as well
            uncorrD = syndromeNonZero & ~checkBitError;
         end
      endcase
   end

   always_ff @(posedge clk_i or negedge rstN_i) begin
      if (!rstN_i) begin
         valid_o       <= 1'b0;
         dataWord_o    <= '0;
         syndrome_o    <= '0;
         parityLo_o    <= 1'b0;
         parityHi_o    <= 1'b0;
         uncorrError_o <= 1'b0;
      end else begin
         valid_o <= valid_i;
         if (valid_i) begin
            dataWord_o    <= dataD;
            syndrome_o    <= syndrome_i;   // Check bits in encode mode
            parityLo_o    <= parityLoD;
            parityHi_o    <= parityHiD;
            uncorrError_o <= uncorrD;
         end
      end
   end

endmodule

// ==== verilog/eccDecoderTop.sv ====
/*
 * SEC-DED decoder top level
 * Two-stage pipeline: syndrome and byte parity stages work side by side,
 * the correction stage combines their results.
 */
`timescale 1ns/1ps

module eccDecoderTop
   import eccPkg::*;
(
   input  logic                  clk_i,
   input  logic                  rstN_i,
   input  logic                  inValid_i,
   input  logic [dataWidth-1:0]  dataWord_i,
   input  logic [checkWidth-1:0] checkBits_i,
   input  opMode_t               mode_i,
   output logic                  outValid_o,
   output logic [dataWidth-1:0]  dataWord_o,
   output logic [checkWidth-1:0] syndrome_o,
   output logic                  parityLo_o,
   output logic                  parityHi_o,
   output logic                  uncorrError_o
);

   logic [checkWidth-1:0] syndromeQ;
   opMode_t               modeQ;
   logic                  stage1Valid;   // Qualifies both stage 1 outputs
   logic [dataWidth-1:0]  dataQ;
   logic                  parityLoQ;
   logic                  parityHiQ;

   syndromeStage syndromeStage_inst (
      .clk_i       (clk_i),
      .rstN_i      (rstN_i),
      .inValid_i   (inValid_i),
      .dataWord_i  (dataWord_i),
      .checkBits_i (checkBits_i),
      .mode_i      (mode_i),
      .syndrome_o  (syndromeQ),
      .mode_o      (modeQ),
      .valid_o     (stage1Valid)
   );

   byteParityStage byteParityStage_inst (
      .clk_i      (clk_i),
      .rstN_i     (rstN_i),
      .inValid_i  (inValid_i),
      .dataWord_i (dataWord_i),
      .data_o     (dataQ),
      .parityLo_o (parityLoQ),
      .parityHi_o (parityHiQ)
   );

   correctionStage correctionStage_inst (
      .clk_i         (clk_i),
      .rstN_i        (rstN_i),
      .valid_i       (stage1Valid),
      .syndrome_i    (syndromeQ),
      .mode_i        (modeQ),
      .data_i        (dataQ),
      .parityLo_i    (parityLoQ),
      .parityHi_i    (parityHiQ),
      .valid_o       (outValid_o),
      .dataWord_o    (dataWord_o),
      .syndrome_o    (syndrome_o),
      .parityLo_o    (parityLo_o),
      .parityHi_o    (parityHi_o),
      .uncorrError_o (uncorrError_o)
   );

endmodule

// ==== verification/eccRefModel.svh ====
/*
 * ECC reference model
 * Expected decoder results straight from the code table, plus the
 * Fibonacci LFSR used for random stimulus.
 */
`ifndef ECC_REF_MODEL_SVH
`define ECC_REF_MODEL_SVH

typedef struct packed {
   logic [dataWidth-1:0]  dataWord;
   logic [checkWidth-1:0] syndrome;
   logic                  parityLo;
   logic                  parityHi;
   logic                  uncorrError;
} eccResult_t;

function automatic eccResult_t eccRefModel(input logic [dataWidth-1:0] data,
                                           input logic [checkWidth-1:0] check,
                                           input opMode_t mode);
   eccResult_t res;
   logic [checkWidth-1:0] syn;
   int hitIdx;
   syn = (mode == modeEncode) ? '0 : check;
   hitIdx = -1;
   for (int i = 0; i < dataWidth; i++) begin
      if (data[i]) syn = syn ^ dataColumns[i];
   end
   for (int i = 0; i < dataWidth; i++) begin
      if (syn == dataColumns[i]) hitIdx = i;
   end
   res.dataWord = data;
   if (mode == modeCorrect && hitIdx >= 0) res.dataWord[hitIdx] = ~data[hitIdx];
   res.syndrome    = syn;
   res.parityLo    = ^res.dataWord[byteWidth-1:0];
   res.parityHi    = ^res.dataWord[dataWidth-1:byteWidth];
   res.uncorrError = (mode != modeEncode) && (syn != '0) && ($countones(syn) != 1)
                     && !(mode == modeCorrect && hitIdx >= 0);
   return res;
endfunction

// Taps 32, 22, 2, 1; the new bit enters at bit 0
function automatic logic [31:0] lfsrNext(input logic [31:0] state);
   return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
endfunction

`endif

// ==== verification/eccDecoderTb.sv ====
/*
 * SEC-DED decoder testbench
 * Drives encode, clean, single-error and double-error words through the
 * two-stage pipeline, with random idle gaps, and checks every result
 * against the reference model and the two-cycle latency.
 */
`timescale 1ns/1ps

module eccDecoderTb import eccPkg::*; ();

   `include "eccRefModel.svh"

   localparam int clkPeriod     = 100;
   localparam int resetCycles   = 8;
   localparam int numEncode     = 20;
   localparam int numClean      = 20;
   localparam int numDataErr    = 20;   // Each sent in correct and detect mode
   localparam int numCheckErr   = 12;
   localparam int numDoubleErr  = 20;   // Each sent in correct and detect mode
   localparam int totalWords    = numEncode + numClean + 2 * numDataErr
                                  + numCheckErr + 2 * numDoubleErr;
   localparam int timeoutCycles = resetCycles + 2 * totalWords + 50;

   logic                  clk_i;
   logic                  rstN_i;
   logic                  inValid_i;
   logic [dataWidth-1:0]  dataWord_i;
   logic [checkWidth-1:0] checkBits_i;
   opMode_t               mode_i;
   logic                  outValid_o;
   logic [dataWidth-1:0]  dataWord_o;
   logic [checkWidth-1:0] syndrome_o;
   logic                  parityLo_o;
   logic                  parityHi_o;
   logic                  uncorrError_o;

   logic [31:0]           lfsrState;
   int                    cycleCnt;
   int                    valueErrors;
   int                    otherErrors;
   eccResult_t            expQ[$];
   int                    cycleQ[$];   // Cycle at which each result is due
   eccResult_t            expRes;
   int                    expCycle;
   eccResult_t            encRes;      // Encoding of a clean word
   logic [dataWidth-1:0]  word;
   logic [checkWidth-1:0] chk;
   int                    pos1;
   int                    pos2;

   eccDecoderTop eccDecoderTop_inst (
      .clk_i         (clk_i),
      .rstN_i        (rstN_i),
      .inValid_i     (inValid_i),
      .dataWord_i    (dataWord_i),
      .checkBits_i   (checkBits_i),
      .mode_i        (mode_i),
      .outValid_o    (outValid_o),
      .dataWord_o    (dataWord_o),
      .syndrome_o    (syndrome_o),
      .parityLo_o    (parityLo_o),
      .parityHi_o    (parityHi_o),
      .uncorrError_o (uncorrError_o)
   );

   always #(clkPeriod / 2) clk_i = ~clk_i;

   always @(posedge clk_i) cycleCnt = cycleCnt + 1;

   // One LFSR step per bit taken
   function automatic logic [31:0] randBits(input int n);
      logic [31:0] val;
      val = '0;
      for (int k = 0; k < n; k++) begin
         lfsrState = lfsrNext(lfsrState);
         val = {val[30:0], lfsrState[0]};
      end
      return val;
   endfunction

   task automatic compareValue(input string sigName, input logic [31:0] expVal,
                               input logic [31:0] actVal);
      if (expVal !== actVal) begin
         valueErrors++;
         $display("FAIL t=%0t %s expected 0x%0h actual 0x%0h",
                  $time, sigName, expVal, actVal);
      end
   endtask

   // Called on a falling edge, returns on a falling edge
   task automatic sendWord(input logic [dataWidth-1:0] data,
                           input logic [checkWidth-1:0] check, input opMode_t mode);
      inValid_i   = 1'b1;
      dataWord_i  = data;
      checkBits_i = check;
      mode_i      = mode;
      expQ.push_back(eccRefModel(data, check, mode));
      cycleQ.push_back(cycleCnt + 2);   // Accepted next edge, valid two edges on
      @(negedge clk_i);
      inValid_i = 1'b0;
      if (randBits(2) == 0) begin
         @(negedge clk_i);              // Occasional idle cycle
      end
   endtask

   // Comparison of every output word
   always @(negedge clk_i) begin
      if (rstN_i && outValid_o) begin
         if (expQ.size() == 0) begin
            otherErrors++;
            $display("Error at %0t: outValid_o is high but no word is outstanding", $time);
         end else begin
            expRes   = expQ.pop_front();
            expCycle = cycleQ.pop_front();
            if (cycleCnt != expCycle) begin
               otherErrors++;
               $display("Error at %0t: result came in cycle %0d instead of cycle %0d",
                        $time, cycleCnt, expCycle);
            end
            compareValue("dataWord_o", expRes.dataWord, dataWord_o);
            compareValue("syndrome_o", expRes.syndrome, syndrome_o);
            compareValue("parityLo_o", expRes.parityLo, parityLo_o);
            compareValue("parityHi_o", expRes.parityHi, parityHi_o);
            compareValue("uncorrError_o", expRes.uncorrError, uncorrError_o);
         end
      end
   end

   initial begin
      #(timeoutCycles * clkPeriod);
      $display("Timeout: the run did not finish within %0d cycles", timeoutCycles);
      $display("Errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
      $display("TESTBENCH FAILED");
      $finish;
   end

   initial begin
      clk_i       = 1'b0;
      rstN_i      = 1'b0;
      inValid_i   = 1'b0;
      dataWord_i  = '0;
      checkBits_i = '0;
      mode_i      = modeEncode;
      cycleCnt    = 0;
      valueErrors = 0;
      otherErrors = 0;
      lfsrState   = 32'h5cfc;

      repeat (resetCycles) @(posedge clk_i);
      @(negedge clk_i);
      compareValue("outValid_o", 0, outValid_o);   // Outputs cleared by reset
      compareValue("uncorrError_o", 0, uncorrError_o);
      compareValue("dataWord_o", 0, dataWord_o);
      compareValue("syndrome_o", 0, syndrome_o);
      compareValue("parityLo_o", 0, parityLo_o);
      compareValue("parityHi_o", 0, parityHi_o);
      rstN_i = 1'b1;
      @(negedge clk_i);
      compareValue("outValid_o", 0, outValid_o);

      for (int n = 0; n < numEncode; n++) begin
         sendWord(randBits(dataWidth), randBits(checkWidth), modeEncode);
      end

      for (int n = 0; n < numClean; n++) begin
         word   = randBits(dataWidth);
         encRes = eccRefModel(word, '0, modeEncode);
         sendWord(word, encRes.syndrome, modeCorrect);
      end

      for (int n = 0; n < numDataErr; n++) begin
         word   = randBits(dataWidth);
         encRes = eccRefModel(word, '0, modeEncode);
         chk    = encRes.syndrome;
         pos1 = randBits(4);
         word[pos1] = ~word[pos1];
         sendWord(word, chk, modeCorrect);
         sendWord(word, chk, modeDetect);       // Same faulty word, not fixed
      end

      for (int n = 0; n < numCheckErr; n++) begin
         word   = randBits(dataWidth);
         encRes = eccRefModel(word, '0, modeEncode);
         chk    = encRes.syndrome;
         pos1 = randBits(3) % checkWidth;
         chk[pos1] = ~chk[pos1];
         sendWord(word, chk, modeCorrect);
      end

      for (int n = 0; n < numDoubleErr; n++) begin
         word   = randBits(dataWidth);
         encRes = eccRefModel(word, '0, modeEncode);
         chk    = encRes.syndrome;
         pos1 = randBits(5) % (dataWidth + checkWidth);
         pos2 = pos1;
         while (pos2 == pos1) begin
            pos2 = randBits(5) % (dataWidth + checkWidth);
         end
         for (int p = 0; p < 2; p++) begin
            if (p == 0 ? pos1 < dataWidth : pos2 < dataWidth) begin
               word[p == 0 ? pos1 : pos2] = ~word[p == 0 ? pos1 : pos2];
            end else begin
               chk[(p == 0 ? pos1 : pos2) - dataWidth] =
                  ~chk[(p == 0 ? pos1 : pos2) - dataWidth];
            end
         end
         sendWord(word, chk, modeCorrect);
         sendWord(word, chk, modeDetect);
      end

      repeat (4) @(negedge clk_i);   // Drain the two-stage pipeline
      if (expQ.size() != 0) begin
         otherErrors++;
         $display("Error: %0d words never came out of the pipeline", expQ.size());
      end

      $display("Errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
      if (valueErrors + otherErrors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

// ==== files.f ====
+incdir+verification
verilog/eccPkg.sv
verilog/syndromeStage.sv
verilog/byteParityStage.sv
verilog/correctionStage.sv
verilog/eccDecoderTop.sv
verification/eccDecoderTb.sv

// ==== Bender.yml ====
package:
  name: eccDecoder

sources:
  - verilog/eccPkg.sv
  - verilog/syndromeStage.sv
  - verilog/byteParityStage.sv
  - verilog/correctionStage.sv
  - verilog/eccDecoderTop.sv
  - target: simulation
    include_dirs:
      - verification
    files:
      - verification/eccDecoderTb.sv
